/* Makefile */
# Verilator build and run for the dual-issue writeback project

VERILATOR ?= verilator
TOP       ?= dual_wb_tb
FILELIST  ?= dual_wb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Testbench failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dual_wb.f */
src/dual_wb_pkg.sv
src/exec_lane.sv
src/wb_stage.sv
src/reg_file.sv
src/dual_wb_top.sv
test/dual_wb_assertions.sv
test/dual_wb_tb.sv

/* src/dual_wb_pkg.sv */
package dual_wb_pkg;

    // Field widths
    localparam int reg_addr_w = 5;
    localparam int word_w     = 32;
    localparam int opcode_w   = 6;
    localparam int funct_w    = 6;
    localparam int imm_w      = 16;

    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [word_w-1:0]     word_t;

    typedef struct packed {
        logic [opcode_w-1:0] opcode;
        reg_addr_t           rs;
        reg_addr_t           rt;
        reg_addr_t           rd;
        logic [4:0]          shamt;
        logic [funct_w-1:0]  funct;
    } r_fmt_t;

    typedef struct packed {
        logic [opcode_w-1:0] opcode;
        reg_addr_t           rs;
        reg_addr_t           rt;
        logic [imm_w-1:0]    imm;
    } i_fmt_t;

    // Same 32-bit word seen in either format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } inst_u;

    // Opcodes
    localparam logic [opcode_w-1:0] op_rtype = 6'h00;
    localparam logic [opcode_w-1:0] op_addi  = 6'h08;
    localparam logic [opcode_w-1:0] op_andi  = 6'h0c;
    localparam logic [opcode_w-1:0] op_ori   = 6'h0d;
    localparam logic [opcode_w-1:0] op_lui   = 6'h0f;

    // R-format funct codes
    localparam logic [funct_w-1:0] fn_add = 6'h20;
    localparam logic [funct_w-1:0] fn_sub = 6'h22;
    localparam logic [funct_w-1:0] fn_and = 6'h24;
    localparam logic [funct_w-1:0] fn_or  = 6'h25;
    localparam logic [funct_w-1:0] fn_xor = 6'h26;
    localparam logic [funct_w-1:0] fn_slt = 6'h2a;

    // Lane result handed to writeback (71 bits)
    typedef struct packed {
        logic      valid;
        logic      gr_we;
        reg_addr_t dest;
        word_t     result;
        word_t     pc;
    } es_to_ws_t;

    // One register file write (70 bits)
    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
        word_t     pc;
    } rf_commit_t;

endpackage

/* src/dual_wb_top.sv */
`timescale 1ns/1ps

module dual_wb_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    issue1_valid,
    input  logic                    issue2_valid,
    input  dual_wb_pkg::word_t      issue1_pc,
    input  dual_wb_pkg::word_t      issue2_pc,
    input  dual_wb_pkg::inst_u      issue1_inst,
    input  dual_wb_pkg::inst_u      issue2_inst,
    output dual_wb_pkg::rf_commit_t commit1,
    output dual_wb_pkg::rf_commit_t commit2,
    input  dual_wb_pkg::reg_addr_t  dbg_raddr,
    output dual_wb_pkg::word_t      dbg_rdata
);

    dual_wb_pkg::reg_addr_t raddr_a;
    dual_wb_pkg::reg_addr_t raddr_b;
    dual_wb_pkg::reg_addr_t raddr_c;
    dual_wb_pkg::reg_addr_t raddr_d;
    dual_wb_pkg::word_t     rdata_a;
    dual_wb_pkg::word_t     rdata_b;
    dual_wb_pkg::word_t     rdata_c;
    dual_wb_pkg::word_t     rdata_d;
    dual_wb_pkg::es_to_ws_t es_to_ws1;
    dual_wb_pkg::es_to_ws_t es_to_ws2;

    // Lane 1 reads through ports a and b
    exec_lane lane1 (
        .clk        (clk),
        .reset      (reset),
        .issue_valid(issue1_valid),
        .issue_pc   (issue1_pc),
        .issue_inst (issue1_inst),
        .raddr1     (raddr_a),
        .raddr2     (raddr_b),
        .rdata1     (rdata_a),
        .rdata2     (rdata_b),
        .es_to_ws   (es_to_ws1)
    );

    // Lane 2 reads through ports c and d
    exec_lane lane2 (
        .clk        (clk),
        .reset      (reset),
        .issue_valid(issue2_valid),
        .issue_pc   (issue2_pc),
        .issue_inst (issue2_inst),
        .raddr1     (raddr_c),
        .raddr2     (raddr_d),
        .rdata1     (rdata_c),
        .rdata2     (rdata_d),
        .es_to_ws   (es_to_ws2)
    );

    wb_stage wb (
        .es_to_ws1(es_to_ws1),
        .es_to_ws2(es_to_ws2),
        .commit1  (commit1),
        .commit2  (commit2)
    );

    reg_file rf (
        .clk      (clk),
        .reset    (reset),
        .raddr_a  (raddr_a),
        .raddr_b  (raddr_b),
        .raddr_c  (raddr_c),
        .raddr_d  (raddr_d),
        .raddr_dbg(dbg_raddr),
        .rdata_a  (rdata_a),
        .rdata_b  (rdata_b),
        .rdata_c  (rdata_c),
        .rdata_d  (rdata_d),
        .rdata_dbg(dbg_rdata),
        .commit1  (commit1),
        .commit2  (commit2)
    );

endmodule

/* src/exec_lane.sv */
`timescale 1ns/1ps

module exec_lane (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   issue_valid,
    input  dual_wb_pkg::word_t     issue_pc,
    input  dual_wb_pkg::inst_u     issue_inst,
    output dual_wb_pkg::reg_addr_t raddr1,
    output dual_wb_pkg::reg_addr_t raddr2,
    input  dual_wb_pkg::word_t     rdata1,
    input  dual_wb_pkg::word_t     rdata2,
    output dual_wb_pkg::es_to_ws_t es_to_ws
);

    dual_wb_pkg::word_t     imm_sext;
    dual_wb_pkg::word_t     imm_zext;
    dual_wb_pkg::word_t     result_c;
    dual_wb_pkg::reg_addr_t dest_c;
    logic                   gr_we_c;

    // rs and rt sit at the same place in both formats
    assign raddr1 = issue_inst.r.rs;
    assign raddr2 = issue_inst.r.rt;

    assign imm_sext = {{16{issue_inst.i.imm[15]}}, issue_inst.i.imm};
    assign imm_zext = {16'b0, issue_inst.i.imm};

    always_comb begin
        result_c = '0;
        dest_c   = issue_inst.i.rt;
        gr_we_c  = 1'b1;
        case (issue_inst.r.opcode)
            dual_wb_pkg::op_rtype: begin
                dest_c = issue_inst.r.rd;
                case (issue_inst.r.funct)
                    dual_wb_pkg::fn_add: result_c = rdata1 + rdata2;
                    dual_wb_pkg::fn_sub: result_c = rdata1 - rdata2;
                    dual_wb_pkg::fn_and: result_c = rdata1 & rdata2;
                    dual_wb_pkg::fn_or:  result_c = rdata1 | rdata2;
                    dual_wb_pkg::fn_xor: result_c = rdata1 ^ rdata2;
                    dual_wb_pkg::fn_slt: begin
                        result_c = {31'b0, $signed(rdata1) < $signed(rdata2)};
                    end
                    default: gr_we_c = 1'b0;
                endcase
            end
            dual_wb_pkg::op_addi: result_c = rdata1 + imm_sext;
            dual_wb_pkg::op_andi: result_c = rdata1 & imm_zext;
            dual_wb_pkg::op_ori:  result_c = rdata1 | imm_zext;
            // Immediate goes to the upper half
            dual_wb_pkg::op_lui:  result_c = {issue_inst.i.imm, 16'b0};
            default: gr_we_c = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            es_to_ws.valid <= 1'b0;
            es_to_ws.gr_we <= 1'b0;
        end else begin
            es_to_ws.valid <= issue_valid;
            es_to_ws.gr_we <= issue_valid & gr_we_c;
        end
        es_to_ws.dest   <= dest_c;
        es_to_ws.result <= result_c;
        es_to_ws.pc     <= issue_pc;
    end

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                    clk,
    input  logic                    reset,
    input  dual_wb_pkg::reg_addr_t  raddr_a,
    input  dual_wb_pkg::reg_addr_t  raddr_b,
    input  dual_wb_pkg::reg_addr_t  raddr_c,
    input  dual_wb_pkg::reg_addr_t  raddr_d,
    input  dual_wb_pkg::reg_addr_t  raddr_dbg,
    output dual_wb_pkg::word_t      rdata_a,
    output dual_wb_pkg::word_t      rdata_b,
    output dual_wb_pkg::word_t      rdata_c,
    output dual_wb_pkg::word_t      rdata_d,
    output dual_wb_pkg::word_t      rdata_dbg,
    input  dual_wb_pkg::rf_commit_t commit1,
    input  dual_wb_pkg::rf_commit_t commit2
);

    dual_wb_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (commit1.we && commit1.waddr != '0) begin
                regs[commit1.waddr] <= commit1.wdata;
            end
            // Port 2 is written last so it wins on the same address
            if (commit2.we && commit2.waddr != '0) begin
                regs[commit2.waddr] <= commit2.wdata;
            end
        end
    end

    assign rdata_a   = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b   = (raddr_b == '0) ? '0 : regs[raddr_b];
    assign rdata_c   = (raddr_c == '0) ? '0 : regs[raddr_c];
    assign rdata_d   = (raddr_d == '0) ? '0 : regs[raddr_d];
    assign rdata_dbg = (raddr_dbg == '0) ? '0 : regs[raddr_dbg];

endmodule

/* src/wb_stage.sv */
`timescale 1ns/1ps

module wb_stage (
    input  dual_wb_pkg::es_to_ws_t  es_to_ws1,
    input  dual_wb_pkg::es_to_ws_t  es_to_ws2,
    output dual_wb_pkg::rf_commit_t commit1,
    output dual_wb_pkg::rf_commit_t commit2
);

    logic lane1_writes;
    logic lane2_writes;
    logic same_dest;

    assign lane1_writes = es_to_ws1.valid & es_to_ws1.gr_we;
    assign lane2_writes = es_to_ws2.valid & es_to_ws2.gr_we;
    assign same_dest    = (es_to_ws1.dest == es_to_ws2.dest);

    // Lane 2 is the younger instruction so its write is kept
    always_comb begin
        commit1.we    = lane1_writes & ~(lane2_writes & same_dest);
        commit1.waddr = es_to_ws1.dest;
        commit1.wdata = es_to_ws1.result;
        commit1.pc    = es_to_ws1.pc;
    end

    always_comb begin
        commit2.we    = lane2_writes;
        commit2.waddr = es_to_ws2.dest;
        commit2.wdata = es_to_ws2.result;
        commit2.pc    = es_to_ws2.pc;
    end

endmodule

/* test/dual_wb_assertions.sv */
`timescale 1ns/1ps

module dual_wb_assertions (
    input logic                    clk,
    input logic                    reset,
    input dual_wb_pkg::rf_commit_t commit1,
    input dual_wb_pkg::rf_commit_t commit2,
    input dual_wb_pkg::reg_addr_t  raddr_dbg,
    input dual_wb_pkg::word_t      rdata_dbg
);

    // Lane 1 must yield when both lanes target one register
    property no_double_write;
        @(posedge clk) disable iff (reset)
            !(commit1.we && commit2.we && commit1.waddr == commit2.waddr);
    endproperty

    // Lane registers are cleared by the first reset edge
    property quiet_in_reset;
        @(posedge clk) (reset && $past(reset)) |-> (!commit1.we && !commit2.we);
    endproperty

    property zero_reg_reads_zero;
        @(posedge clk) (raddr_dbg == '0) |-> (rdata_dbg == '0);
    endproperty

    a_no_double_write: assert property (no_double_write)
        else $error("commit1 and commit2 both write register %0d", commit1.waddr);

    a_quiet_in_reset: assert property (quiet_in_reset)
        else $error("commit write enable high during reset");

    a_zero_reg: assert property (zero_reg_reads_zero)
        else $error("register 0 reads %h", rdata_dbg);

endmodule

/* test/dual_wb_tb.sv */
`timescale 1ns/1ps

module dual_wb_tb;

    logic                    clk;
    logic                    reset;
    logic                    issue1_valid;
    logic                    issue2_valid;
    dual_wb_pkg::word_t      issue1_pc;
    dual_wb_pkg::word_t      issue2_pc;
    dual_wb_pkg::inst_u      issue1_inst;
    dual_wb_pkg::inst_u      issue2_inst;
    dual_wb_pkg::rf_commit_t commit1;
    dual_wb_pkg::rf_commit_t commit2;
    dual_wb_pkg::reg_addr_t  dbg_raddr;
    dual_wb_pkg::word_t      dbg_rdata;

    integer                  seed;
    int                      errors;
    int                      checks;
    logic [31:0]             rnd;
    dual_wb_pkg::word_t      pc_count;
    dual_wb_pkg::word_t      model_regs [32];
    // Commits expected in the cycle after the current issue edge
    dual_wb_pkg::rf_commit_t exp1;
    dual_wb_pkg::rf_commit_t exp2;

    dual_wb_top uut (
        .clk         (clk),
        .reset       (reset),
        .issue1_valid(issue1_valid),
        .issue2_valid(issue2_valid),
        .issue1_pc   (issue1_pc),
        .issue2_pc   (issue2_pc),
        .issue1_inst (issue1_inst),
        .issue2_inst (issue2_inst),
        .commit1     (commit1),
        .commit2     (commit2),
        .dbg_raddr   (dbg_raddr),
        .dbg_rdata   (dbg_rdata)
    );

    bind reg_file dual_wb_assertions checks (
        .clk      (clk),
        .reset    (reset),
        .commit1  (commit1),
        .commit2  (commit2),
        .raddr_dbg(raddr_dbg),
        .rdata_dbg(rdata_dbg)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic dual_wb_pkg::inst_u r_format(input dual_wb_pkg::reg_addr_t rs,
                                                    input dual_wb_pkg::reg_addr_t rt,
                                                    input dual_wb_pkg::reg_addr_t rd,
                                                    input logic [5:0] funct);
        dual_wb_pkg::inst_u inst;
        inst.r.opcode = dual_wb_pkg::op_rtype;
        inst.r.rs     = rs;
        inst.r.rt     = rt;
        inst.r.rd     = rd;
        inst.r.shamt  = 5'd0;
        inst.r.funct  = funct;
        return inst;
    endfunction

    function automatic dual_wb_pkg::inst_u i_format(input logic [5:0] opcode,
                                                    input dual_wb_pkg::reg_addr_t rs,
                                                    input dual_wb_pkg::reg_addr_t rt,
                                                    input logic [15:0] imm);
        dual_wb_pkg::inst_u inst;
        inst.i.opcode = opcode;
        inst.i.rs     = rs;
        inst.i.rt     = rt;
        inst.i.imm    = imm;
        return inst;
    endfunction

    // Registers 0 to 3 only so that conflicts and r0 writes come up often
    function automatic dual_wb_pkg::inst_u random_inst();
        logic [31:0]            r;
        logic [3:0]             kind;
        dual_wb_pkg::reg_addr_t rs;
        dual_wb_pkg::reg_addr_t rt;
        dual_wb_pkg::reg_addr_t rd;
        dual_wb_pkg::inst_u     inst;
        r    = $random(seed);
        kind = r[3:0] % 4'd12;
        rs   = {3'b0, r[5:4]};
        rt   = {3'b0, r[7:6]};
        rd   = {3'b0, r[9:8]};
        case (kind)
            4'd0: inst = r_format(rs, rt, rd, dual_wb_pkg::fn_add);
            4'd1: inst = r_format(rs, rt, rd, dual_wb_pkg::fn_sub);
            4'd2: inst = r_format(rs, rt, rd, dual_wb_pkg::fn_and);
            4'd3: inst = r_format(rs, rt, rd, dual_wb_pkg::fn_or);
            4'd4: inst = r_format(rs, rt, rd, dual_wb_pkg::fn_xor);
            4'd5: inst = r_format(rs, rt, rd, dual_wb_pkg::fn_slt);
            4'd6: inst = i_format(dual_wb_pkg::op_addi, rs, rt, r[31:16]);
            4'd7: inst = i_format(dual_wb_pkg::op_andi, rs, rt, r[31:16]);
            4'd8: inst = i_format(dual_wb_pkg::op_ori, rs, rt, r[31:16]);
            4'd9: inst = i_format(dual_wb_pkg::op_lui, rs, rt, r[31:16]);
            4'd10: inst = i_format(6'h3f, rs, rt, r[31:16]);
            default: inst = r_format(rs, rt, rd, 6'h3f);
        endcase
        return inst;
    endfunction

    // Expected commit of one lane from the model as it stands at issue
    function automatic dual_wb_pkg::rf_commit_t model_lane(input logic valid,
                                                           input dual_wb_pkg::word_t pc,
                                                           input dual_wb_pkg::inst_u inst);
        dual_wb_pkg::rf_commit_t c;
        dual_wb_pkg::word_t      a;
        dual_wb_pkg::word_t      b;
        logic                    known;
        a       = model_regs[inst.i.rs];
        b       = model_regs[inst.i.rt];
        known   = 1'b1;
        c.wdata = '0;
        c.waddr = inst.i.rt;
        if (inst.r.opcode == dual_wb_pkg::op_rtype) begin
            c.waddr = inst.r.rd;
            if (inst.r.funct == dual_wb_pkg::fn_add) c.wdata = a + b;
            else if (inst.r.funct == dual_wb_pkg::fn_sub) c.wdata = a - b;
            else if (inst.r.funct == dual_wb_pkg::fn_and) c.wdata = a & b;
            else if (inst.r.funct == dual_wb_pkg::fn_or) c.wdata = a | b;
            else if (inst.r.funct == dual_wb_pkg::fn_xor) c.wdata = a ^ b;
            else if (inst.r.funct == dual_wb_pkg::fn_slt) begin
                c.wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            end else known = 1'b0;
        end else if (inst.i.opcode == dual_wb_pkg::op_addi) begin
            c.wdata = a + {{16{inst.i.imm[15]}}, inst.i.imm};
        end else if (inst.i.opcode == dual_wb_pkg::op_andi) begin
            c.wdata = a & {16'h0000, inst.i.imm};
        end else if (inst.i.opcode == dual_wb_pkg::op_ori) begin
            c.wdata = a | {16'h0000, inst.i.imm};
        end else if (inst.i.opcode == dual_wb_pkg::op_lui) begin
            c.wdata = {inst.i.imm, 16'h0000};
        end else known = 1'b0;
        c.we = valid & known;
        c.pc = pc;
        return c;
    endfunction

    task automatic check_commit(input string name, input dual_wb_pkg::rf_commit_t got,
                                input dual_wb_pkg::rf_commit_t exp);
        checks++;
        if (got.we !== exp.we || (exp.we && (got.waddr !== exp.waddr ||
                got.wdata !== exp.wdata || got.pc !== exp.pc))) begin
            errors++;
            $display("Fail %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input dual_wb_pkg::word_t got,
                              input dual_wb_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset        <= 1'b1;
        // Writing instructions stay valid so that the lane reset is exercised
        issue1_valid <= 1'b1;
        issue2_valid <= 1'b1;
        issue1_inst  <= i_format(dual_wb_pkg::op_lui, 5'd0, 5'd5, 16'h5a5a);
        issue2_inst  <= i_format(dual_wb_pkg::op_lui, 5'd0, 5'd6, 16'ha5a5);
        repeat (5) @(posedge clk);
        reset        <= 1'b0;
        issue1_valid <= 1'b0;
        issue2_valid <= 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        exp1 = '0;
        exp2 = '0;
    endtask

    // Drive both slots for one cycle and check the commits issued one cycle earlier
    task automatic step(input logic v1, input dual_wb_pkg::inst_u i1,
                        input logic v2, input dual_wb_pkg::inst_u i2);
        dual_wb_pkg::rf_commit_t next1;
        dual_wb_pkg::rf_commit_t next2;
        dual_wb_pkg::reg_addr_t  dbg;
        logic [31:0]             r;
        r   = $random(seed);
        dbg = r[4:0];
        @(posedge clk);
        pc_count = pc_count + 32'd8;
        issue1_valid <= v1;
        issue1_inst  <= i1;
        issue1_pc    <= pc_count;
        issue2_valid <= v2;
        issue2_inst  <= i2;
        issue2_pc    <= pc_count + 32'd4;
        dbg_raddr    <= dbg;
        @(negedge clk);
        check_commit("commit1", commit1, exp1);
        check_commit("commit2", commit2, exp2);
        check_word("dbg_rdata", dbg_rdata, model_regs[dbg]);
        next1 = model_lane(v1, pc_count, i1);
        next2 = model_lane(v2, pc_count + 32'd4, i2);
        if (next2.we && next1.waddr == next2.waddr) next1.we = 1'b0;
        // Commits seen now land at the next edge with lane 2 last
        if (exp1.we && exp1.waddr != 5'd0) model_regs[exp1.waddr] = exp1.wdata;
        if (exp2.we && exp2.waddr != 5'd0) model_regs[exp2.waddr] = exp2.wdata;
        exp1 = next1;
        exp2 = next2;
    endtask

    task automatic measure_latency();
        dual_wb_pkg::rf_commit_t exp;
        int                      edges;
        exp.we    = 1'b1;
        exp.waddr = 5'd3;
        exp.wdata = 32'h1234_0000;
        exp.pc    = 32'h0000_0100;
        @(posedge clk);
        issue1_valid <= 1'b1;
        issue1_inst  <= i_format(dual_wb_pkg::op_lui, 5'd0, 5'd3, 16'h1234);
        issue1_pc    <= 32'h0000_0100;
        @(posedge clk);
        issue1_valid <= 1'b0;
        edges = 1;
        @(negedge clk);
        while (!commit1.we && edges < 8) begin
            @(negedge clk);
            edges++;
        end
        if (!commit1.we) begin
            errors++;
            $display("Timed out waiting for commit1 after a single lui issue");
        end else if (edges != 1) begin
            errors++;
            $display("Commit appeared %0d edges after issue instead of one", edges);
        end else begin
            check_commit("commit1", commit1, exp);
        end
    endtask

    initial begin
        seed     = 32'h82ca_7563;
        errors   = 0;
        checks   = 0;
        pc_count = 32'h0000_1000;
        reset        <= 1'b1;
        issue1_valid <= 1'b0;
        issue2_valid <= 1'b0;
        issue1_pc    <= '0;
        issue2_pc    <= '0;
        issue1_inst  <= '0;
        issue2_inst  <= '0;
        dbg_raddr    <= '0;
        apply_reset();
        measure_latency();
        apply_reset();

        // Dependence on r1, a shared destination and writes to r0
        step(1'b1, i_format(dual_wb_pkg::op_lui, 5'd0, 5'd1, 16'h8000),
             1'b0, i_format(dual_wb_pkg::op_lui, 5'd0, 5'd2, 16'h0001));
        step(1'b1, i_format(dual_wb_pkg::op_addi, 5'd1, 5'd2, 16'h0005),
             1'b1, r_format(5'd1, 5'd1, 5'd3, dual_wb_pkg::fn_add));
        step(1'b1, i_format(dual_wb_pkg::op_addi, 5'd1, 5'd2, 16'hffff),
             1'b1, r_format(5'd1, 5'd2, 5'd3, dual_wb_pkg::fn_slt));
        step(1'b1, i_format(dual_wb_pkg::op_ori, 5'd1, 5'd3, 16'hf0f0),
             1'b1, i_format(dual_wb_pkg::op_andi, 5'd1, 5'd3, 16'h0ff0));
        step(1'b1, i_format(dual_wb_pkg::op_lui, 5'd0, 5'd0, 16'hbeef),
             1'b1, r_format(5'd1, 5'd3, 5'd0, dual_wb_pkg::fn_or));

        repeat (400) begin
            rnd = $random(seed);
            step(rnd[2:0] != 3'd0, random_inst(), rnd[5:3] != 3'd0, random_inst());
        end
        // Two idle cycles let the last commits land
        step(1'b0, '0, 1'b0, '0);
        step(1'b0, '0, 1'b0, '0);

        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            dbg_raddr <= i[4:0];
            @(negedge clk);
            check_word("dbg_rdata", dbg_rdata, model_regs[i]);
        end

        $display("Checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
